//--- verilog.f
+incdir+src
src/ice_spi_pkg.sv
src/spi_msg_rx.sv
src/spi_cmd_decode.sv
src/spi_resp_tx.sv
src/ice_spi_top.sv
test/tb_ice_spi.sv

//--- test/tb_ice_spi.sv
`include "ice_spi_settings.svh"

module tb_ice_spi;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_MSGS = 48;

    logic              ice_st_spi_clk;
    logic              spi_cs;
    logic [3:0]        spi_d_in;
    logic [7:0]        spi_d_out;
    logic              spi_d_oe;
    ice_spi_pkg::led_t led;

    // Reference model state
    logic [15:0]                   lfsr_state;
    logic [`ICE_SPI_LED_WIDTH-1:0] model_led;
    logic                          led_known;

    ice_spi_top u_dut (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe),
        .led            (led)
    );

    initial begin
        ice_st_spi_clk = 1'b0;
        forever #10 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    // ========================================
    // Helpers
    // ========================================

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step for every bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen in time", what);
        $display("Testbench failed");
        $fatal(1, "wait limit reached");
    endtask

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic next_edge();
        @(posedge ice_st_spi_clk);
        #2;
    endtask

    task automatic check_led(input string what);
        if (led_known) begin
            check_value(64'(led), 64'(model_led), what);
        end
    endtask

    task automatic wait_oe_rise(input int limit, output int edges);
        edges = 0;
        while (!spi_d_oe) begin
            if (edges == limit) begin
                report_timeout("rise of spi_d_oe after an echo");
            end
            next_edge();
            edges++;
        end
    endtask

    task automatic wait_oe_fall(input int limit);
        int edges;
        edges = 0;
        while (spi_d_oe) begin
            if (edges == limit) begin
                report_timeout("fall of spi_d_oe after deselect");
            end
            next_edge();
            edges++;
        end
    endtask

    // ========================================
    // One selection
    // ========================================

    // cut_edge of zero sends the whole message, otherwise spi_cs drops after that edge
    task automatic send_message(input logic [7:0] sent_type, input logic [55:0] arg,
                                input int cut_edge);
        logic [63:0] sent;
        logic [7:0]  eff_type;
        logic        known;
        logic        want_resp;
        logic [7:0]  pairs [8];
        logic [63:0] got_resp;
        int          oe_edges;
        int          last_edge;
        sent      = {sent_type, arg};
        eff_type  = {1'b1, sent_type[6:0]};
        known     = (eff_type == `ICE_SPI_TYPE_ECHO) || (eff_type == `ICE_SPI_TYPE_LED_SET)
                    || (eff_type == `ICE_SPI_TYPE_NOP);
        want_resp = known && eff_type[`ICE_SPI_TYPE_RESP_BIT];
        last_edge = (cut_edge != 0) ? cut_edge : 18;

        check_value(64'(spi_d_oe), 64'd0, "spi_d_oe before select");
        spi_cs   = 1'b1;
        spi_d_in = 4'(rand_bits(4));
        for (int e = 1; e <= last_edge; e++) begin
            next_edge();
            check_value(64'(spi_d_oe), 64'd0, "spi_d_oe during command");
            check_led("led during command");
            // Nibble for edge e+1, dummy byte first
            if (e < 2 || e >= 18) begin
                spi_d_in = 4'(rand_bits(4));
            end else begin
                spi_d_in = sent[63 - 4*(e-2) -: 4];
            end
        end

        if (cut_edge != 0) begin
            // Aborted message must leave no trace
            spi_cs = 1'b0;
            #1;
            for (int e = 0; e < 12; e++) begin
                next_edge();
                check_value(64'(spi_d_oe), 64'd0, "spi_d_oe after cut message");
                check_led("led after cut message");
            end
        end else begin
            next_edge();
            check_value(64'(spi_d_oe), 64'd0, "spi_d_oe at decode edge");
            if (eff_type == `ICE_SPI_TYPE_LED_SET) begin
                model_led = arg[`ICE_SPI_LED_WIDTH-1:0];
                led_known = 1'b1;
            end
            check_led("led after decode edge");
            if (want_resp) begin
                wait_oe_rise(8, oe_edges);
                check_value(64'(oe_edges), 64'd1, "edges from decode to spi_d_oe");
                for (int k = 0; k < 8; k++) begin
                    if (k > 0) begin
                        next_edge();
                    end
                    pairs[k] = spi_d_out;
                    check_value(64'(spi_d_oe), 64'd1, "spi_d_oe during response");
                    check_led("led during response");
                end
                // Word k: nibbles 3 and 1 first, then 2 and 0
                got_resp = '0;
                for (int w = 0; w < 4; w++) begin
                    got_resp = {got_resp[47:0], pairs[2*w][7:4], pairs[2*w+1][7:4],
                                pairs[2*w][3:0], pairs[2*w+1][3:0]};
                end
                check_value(got_resp, {arg, 8'h00}, "echo response");
                next_edge();
                check_value(64'(spi_d_out), 64'd0, "spi_d_out after last pair");
                check_value(64'(spi_d_oe), 64'd1, "spi_d_oe after last pair");
            end else begin
                for (int e = 20; e <= 28; e++) begin
                    next_edge();
                    check_value(64'(spi_d_oe), 64'd0, "spi_d_oe without response");
                    check_led("led without response");
                end
            end
            spi_cs = 1'b0;
            #1;
            wait_oe_fall(2);
        end

        // Short idle gap with the link deselected
        spi_d_in = 4'h0;
        for (int e = 0; e < 2; e++) begin
            next_edge();
            check_led("led while deselected");
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        logic [7:0]  sent_type;
        logic [55:0] arg;
        logic [2:0]  kind;
        int          cut_edge;
        spi_cs     = 1'b0;
        spi_d_in   = 4'h0;
        lfsr_state = 16'd59;
        model_led  = '0;
        led_known  = 1'b0;

        repeat (10) @(posedge ice_st_spi_clk);
        #2;
        check_value(64'(spi_d_oe), 64'd0, "spi_d_oe after reset");

        // LED value is undefined until the first LED set
        send_message(8'(`ICE_SPI_TYPE_LED_SET) & 8'h7F, 56'(rand_bits(56)), 0);

        for (int n = 0; n < NUM_MSGS; n++) begin
            kind = 3'(rand_bits(3));
            arg  = 56'(rand_bits(56));
            case (kind)
                3'd0, 3'd1, 3'd2: sent_type = 8'(`ICE_SPI_TYPE_ECHO) & 8'h7F;
                3'd3:             sent_type = 8'(`ICE_SPI_TYPE_LED_SET) & 8'h7F;
                3'd4:             sent_type = 8'(`ICE_SPI_TYPE_NOP) & 8'h7F;
                // Mostly unknown types with the response bit set
                3'd5, 3'd6:       sent_type = {2'b01, 6'(rand_bits(6))};
                default:          sent_type = {1'b0, 7'(rand_bits(7))};
            endcase
            cut_edge = 0;
            if (n % 8 == 7) begin
                // Cut short LED set or echo with an LED value that would show if applied
                if (n % 16 == 7) begin
                    sent_type = 8'(`ICE_SPI_TYPE_LED_SET) & 8'h7F;
                end else begin
                    sent_type = 8'(`ICE_SPI_TYPE_ECHO) & 8'h7F;
                end
                arg[`ICE_SPI_LED_WIDTH-1:0] = ~model_led;
                cut_edge = 3 + int'(rand_bits(4)) % 15;
            end
            send_message(sent_type, arg, cut_edge);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- src/ice_spi_top.sv
module ice_spi_top (
    input  logic              ice_st_spi_clk,
    input  logic              spi_cs,
    input  logic [3:0]        spi_d_in,
    output logic [7:0]        spi_d_out,
    output logic              spi_d_oe,
    output ice_spi_pkg::led_t led
);

    // Receiver to decoder
    ice_spi_pkg::msg_t msg;
    logic              msg_valid;

    // Decoder to serializer
    ice_spi_pkg::resp_t resp;
    logic               resp_valid;

    // ========================================
    // Command receive
    // ========================================

    spi_msg_rx u_msg_rx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .msg            (msg),
        .msg_valid      (msg_valid)
    );

    // ========================================
    // Decode and LED
    // ========================================

    spi_cmd_decode u_cmd_decode (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .resp           (resp),
        .resp_valid     (resp_valid),
        .led            (led)
    );

    // ========================================
    // Response out
    // ========================================

    // Tristate buffers sit on the board, driven from spi_d_oe
    spi_resp_tx u_resp_tx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (resp),
        .resp_valid     (resp_valid),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe)
    );

endmodule

//--- src/spi_resp_tx.sv
`include "ice_spi_settings.svh"

module spi_resp_tx (
    input  logic               ice_st_spi_clk,
    input  logic               spi_cs,
    input  ice_spi_pkg::resp_t resp,
    input  logic               resp_valid,
    output logic [7:0]         spi_d_out,
    output logic               spi_d_oe
);

    localparam int WORD_LEN = `ICE_SPI_RESP_LEN / `ICE_SPI_RESP_WORDS;

    logic [WORD_LEN-1:0] word_q;
    ice_spi_pkg::resp_t  rest_q;     // words still waiting to go out
    logic                second_q;

    // ========================================
    // Output word
    // ========================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            spi_d_oe <= 1'b0;
            second_q <= 1'b0;
            word_q   <= '0;
        end else if (resp_valid) begin
            spi_d_oe <= 1'b1;
            second_q <= 1'b0;
            word_q   <= resp[`ICE_SPI_RESP_LEN-1 -: WORD_LEN];
        end else if (spi_d_oe) begin
            second_q <= !second_q;
            // Two nibble pairs per word, then the next word
            if (second_q) begin
                word_q <= rest_q[`ICE_SPI_RESP_LEN-1 -: WORD_LEN];
            end else begin
                word_q <= {word_q[WORD_LEN-5:0], 4'h0};
            end
        end
    end

    // Remaining words, zero once the response is used up
    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_valid) begin
            rest_q <= resp << WORD_LEN;
        end else if (spi_d_oe && second_q) begin
            rest_q <= rest_q << WORD_LEN;
        end
    end

    // Dual-flash layout: high lines from byte 1, low lines from byte 0
    assign spi_d_out = {word_q[WORD_LEN-1 -: 4], word_q[WORD_LEN/2-1 -: 4]};

    // Lines are only driven after a response was handed over
    a_oe_needs_resp: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(spi_d_oe) |-> $past(resp_valid)
    );

endmodule

//--- src/spi_cmd_decode.sv
`include "ice_spi_settings.svh"

module spi_cmd_decode (
    input  logic               ice_st_spi_clk,
    input  logic               spi_cs,
    input  ice_spi_pkg::msg_t  msg,
    input  logic               msg_valid,
    output ice_spi_pkg::resp_t resp,
    output logic               resp_valid,
    output ice_spi_pkg::led_t  led
);

    // Zero bits below the echoed argument
    localparam int PAD_LEN = `ICE_SPI_RESP_LEN - `ICE_SPI_ARG_LEN;

    logic type_known;
    logic is_echo;
    logic is_led_set;
    logic want_resp;

    // ========================================
    // Type decode
    // ========================================

    always_comb begin
        type_known = 1'b0;
        case (msg.msg_type)
            `ICE_SPI_TYPE_ECHO,
            `ICE_SPI_TYPE_LED_SET,
            `ICE_SPI_TYPE_NOP: begin
                type_known = 1'b1;
            end
            default: begin
                type_known = 1'b0;
            end
        endcase
    end

    assign is_echo    = (msg.msg_type == `ICE_SPI_TYPE_ECHO);
    assign is_led_set = (msg.msg_type == `ICE_SPI_TYPE_LED_SET);

    // Unknown types never answer, even with the response bit set
    assign want_resp = type_known && msg.msg_type[`ICE_SPI_TYPE_RESP_BIT];

    // ========================================
    // Response strobe
    // ========================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= msg_valid && want_resp;
        end
    end

    // Response payload
    // Echo returns the argument left aligned
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid && is_echo) begin
            resp <= {msg.arg, {PAD_LEN{1'b0}}};
        end
    end

    // ========================================
    // LED register
    // ========================================

    // Keeps its value across deselects
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid && is_led_set) begin
            led <= msg.arg[`ICE_SPI_LED_WIDTH-1:0];
        end
    end

    // A response only follows a decoded message
    a_resp_after_msg: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        resp_valid |-> $past(msg_valid)
    );

endmodule

//--- src/spi_msg_rx.sv
`include "ice_spi_settings.svh"

module spi_msg_rx (
    input  logic              ice_st_spi_clk,
    input  logic              spi_cs,
    input  logic [3:0]        spi_d_in,
    output ice_spi_pkg::msg_t msg,
    output logic              msg_valid
);

    // Nibble positions within one selection
    localparam int MSG_FIRST = `ICE_SPI_DUMMY_NIBBLES;
    localparam int MSG_LAST  = `ICE_SPI_DUMMY_NIBBLES + `ICE_SPI_MSG_NIBBLES - 1;
    localparam int CNT_PARK  = MSG_LAST + 1;
    localparam int CNT_W     = $clog2(CNT_PARK + 1);

    logic [CNT_W-1:0]            nib_cnt;
    logic [`ICE_SPI_MSG_LEN-1:0] shift_q;
    logic                        in_msg;

    // ========================================
    // Nibble counter
    // ========================================

    // High while the current nibble belongs to the message
    assign in_msg = (nib_cnt >= CNT_W'(MSG_FIRST)) && (nib_cnt <= CNT_W'(MSG_LAST));

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            nib_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            // Count through dummy and message, then park
            if (nib_cnt != CNT_W'(CNT_PARK)) begin
                nib_cnt <= nib_cnt + 1'b1;
            end
            msg_valid <= (nib_cnt == CNT_W'(MSG_LAST));
        end
    end

    // ========================================
    // Message shift register
    // ========================================

    // MSB first, one nibble per clock
    always_ff @(posedge ice_st_spi_clk) begin
        if (in_msg) begin
            shift_q <= {shift_q[`ICE_SPI_MSG_LEN-5:0], spi_d_in};
        end
    end

    // The host cannot send a type with its top bit set, so it is forced here
    assign msg = {1'b1, shift_q[`ICE_SPI_MSG_LEN-2:0]};

    // At most one message strobe per selection
    a_one_msg_per_sel: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg_valid |=> always !msg_valid
    );

    // Message stays put from its strobe until deselect
    a_msg_stable: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg_valid |=> always $stable(msg)
    );

endmodule

//--- src/ice_spi_pkg.sv
`include "ice_spi_settings.svh"

package ice_spi_pkg;

    // ========================================
    // Command message
    // ========================================

    typedef logic [`ICE_SPI_TYPE_LEN-1:0] msg_type_t;
    typedef logic [`ICE_SPI_ARG_LEN-1:0]  msg_arg_t;

    // Type occupies the top byte, argument the rest
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } msg_t;

    // ========================================
    // Response and board state
    // ========================================

    typedef logic [`ICE_SPI_RESP_LEN-1:0] resp_t;

    typedef logic [`ICE_SPI_LED_WIDTH-1:0] led_t;

endpackage

//--- src/ice_spi_settings.svh
`ifndef ICE_SPI_SETTINGS_SVH
`define ICE_SPI_SETTINGS_SVH

// ========================================
// Message layout
// ========================================

// Command message from the host, type on top
`define ICE_SPI_MSG_LEN         64
`define ICE_SPI_TYPE_LEN        8
`define ICE_SPI_ARG_LEN         56

// Response sent back on all eight lines
`define ICE_SPI_RESP_LEN        64
`define ICE_SPI_RESP_WORDS      4

// Nibble counts on the four command lines
// The host sends one dummy byte before every message
`define ICE_SPI_DUMMY_NIBBLES   2
`define ICE_SPI_MSG_NIBBLES     16

// ========================================
// Message types
// ========================================

// Set in the type when the host waits for a response
`define ICE_SPI_TYPE_RESP_BIT   6

`define ICE_SPI_TYPE_ECHO       8'hC0
`define ICE_SPI_TYPE_LED_SET    8'h81
`define ICE_SPI_TYPE_NOP        8'h80

// Board LEDs
`define ICE_SPI_LED_WIDTH       4

`endif
